// ==== source/stride_defs.svh ====
/*
 * Stride index generator sizing
 * Widths of indices, shift amounts and route tags, and the request
 * queue geometry with its almost-full level
 */
`ifndef STRIDE_DEFS_SVH
`define STRIDE_DEFS_SVH

// Vertex index, stride and address width
`define STRIDE_INDEX_W 32
`define STRIDE_SHIFT_W 5
`define STRIDE_ROUTE_W 8

// Request queue
`define STRIDE_FIFO_DEPTH 16
`define STRIDE_FIFO_PTR_W 4
`define STRIDE_PROG_FULL 8

`endif

// ==== source/stride_config_pkg.sv ====
/*
 * Stride job configuration types
 * Holds the job descriptor, the offset shift control and the
 * sequencer state encoding
 */
`default_nettype none

`include "stride_defs.svh"

package stride_config_pkg;

    // Direction 1 shifts left, 0 shifts right
    typedef struct packed {
        logic                       direction;
        logic [`STRIDE_SHIFT_W-1:0] amount;
    } address_shift_t;

    typedef struct packed {
        logic [`STRIDE_INDEX_W-1:0] index_start;
        logic [`STRIDE_INDEX_W-1:0] index_end;
        logic [`STRIDE_INDEX_W-1:0] stride;
        logic [`STRIDE_ROUTE_W-1:0] route;
        address_shift_t             shift;
    } stride_job_t;

    typedef enum logic [3:0] {
        RESET,
        IDLE,
        SETUP,
        START,
        BUSY,
        BUSY_TRANS,
        PAUSE_TRANS,
        PAUSE,
        DONE
    } sequencer_state_t;

endpackage

`default_nettype wire

// ==== source/memory_packet_pkg.sv ====
/*
 * Memory request packet
 * One request per generated vertex index, carrying the address
 * pieces and the route tag toward the memory side
 */
`default_nettype none

`include "stride_defs.svh"

package memory_packet_pkg;

    // ------------------------------------------------------------------------
    // Request payload as queued in the request FIFO
    // ------------------------------------------------------------------------
    typedef struct packed {
        // Destination of the request
        logic [`STRIDE_ROUTE_W-1:0]     route;
        // Base is the job start index
        logic [`STRIDE_INDEX_W-1:0]     base;
        // Index after the configured shift
        logic [`STRIDE_INDEX_W-1:0]     offset;
        stride_config_pkg::address_shift_t shift;
        logic [`STRIDE_INDEX_W-1:0]     index;
    } request_payload_t;

    // 110 bits with the default widths
    localparam int unsigned REQUEST_PAYLOAD_W = $bits(request_payload_t);

endpackage

`default_nettype wire

// ==== source/stride_ifs.sv ====
/*
 * Stride generator internal buses
 * Counter control between sequencer and counter, and the request
 * queue port shared by formatter, FIFO and top level
 */
`timescale 1ns/1ps
`default_nettype none

`include "stride_defs.svh"

interface index_counter_if;
    logic                       enable;
    logic                       load;
    logic                       step;
    logic [`STRIDE_INDEX_W-1:0] load_value;
    logic [`STRIDE_INDEX_W-1:0] stride_value;
    logic [`STRIDE_INDEX_W-1:0] count;

    modport initiator (output enable, load, step, load_value, stride_value, input count);
    modport target    (input enable, load, step, load_value, stride_value, output count);
endinterface

interface request_fifo_if import memory_packet_pkg::*; ();
    // Write side
    logic             wr_en;
    request_payload_t din;
    // Read side
    logic             rd_en;
    request_payload_t dout;
    logic             valid;
    // Status
    logic             empty;
    logic             full;
    logic             prog_full;

    modport writer  (output wr_en, din);
    modport storage (input wr_en, din, rd_en, output dout, valid, empty, full, prog_full);
    // Back-pressure observer for the sequencer
    modport monitor (input prog_full);
endinterface

`default_nettype wire

// ==== source/index_counter.sv ====
/*
 * Vertex index counter
 * Loads the job start index and advances by the stride on each
 * enabled step
 */
`timescale 1ns/1ps
`default_nettype none

module index_counter (
    input  logic              ap_clk,
    input  logic              areset_engine,
    index_counter_if.target   cnt
);

    // ------------------------------------------------------------------------
    // Count register
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            cnt.count <= '0;
        end
        else if (cnt.enable) begin
            // Load has priority over step
            if (cnt.load) begin
                cnt.count <= cnt.load_value;
            end
            else if (cnt.step) begin
                cnt.count <= cnt.count + cnt.stride_value;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/stride_sequencer.sv ====
/*
 * Stride generation sequencer
 * Captures one job while idle, loads the index counter and steps it
 * through the job, holding off while the request queue is almost
 * full or the engine is paused
 */
`timescale 1ns/1ps
`default_nettype none

module stride_sequencer import stride_config_pkg::*; (
    input  logic                      ap_clk,
    input  logic                      areset_engine,
    input  logic                      cfg_valid,
    input  logic                      pause,
    input  stride_job_t               cfg_in,
    output stride_job_t               job,
    index_counter_if.initiator        cnt,
    request_fifo_if.monitor           fifo_mon,
    output logic                      emit,
    output logic                      ready,
    output logic                      done
);

    sequencer_state_t state;
    sequencer_state_t next_state;
    logic             pause_reg;
    logic             accept;
    logic             below_end;
    logic             hold_off;

    // ------------------------------------------------------------------------
    // Job capture
    // ------------------------------------------------------------------------
    assign accept = (state == IDLE) & ready & done & cfg_valid;

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            pause_reg <= 1'b0;
        end
        else begin
            pause_reg <= pause;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (accept) begin
            job <= cfg_in;
        end
    end

    assign below_end = (cnt.count < job.index_end);
    assign hold_off  = fifo_mon.prog_full | pause_reg;

    // ------------------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            state <= RESET;
        end
        else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET:       next_state = IDLE;
            IDLE: begin
                if (accept) begin
                    next_state = SETUP;
                end
            end
            SETUP:       next_state = START;
            START:       next_state = BUSY;
            BUSY: begin
                if (!below_end) begin
                    next_state = DONE;
                end
                else if (hold_off) begin
                    next_state = PAUSE_TRANS;
                end
            end
            BUSY_TRANS:  next_state = BUSY;
            PAUSE_TRANS: next_state = PAUSE;
            PAUSE: begin
                if (!hold_off) begin
                    next_state = BUSY_TRANS;
                end
            end
            DONE:        next_state = IDLE;
            default:     next_state = RESET;
        endcase
    end

    // ------------------------------------------------------------------------
    // Counter control
    // ------------------------------------------------------------------------
    // One index per BUSY cycle; the step moves past the emitted index
    assign emit = (state == BUSY) & below_end;

    assign cnt.enable       = (state == SETUP) | (state == BUSY);
    assign cnt.load         = (state == SETUP);
    assign cnt.step         = emit;
    assign cnt.load_value   = job.index_start;
    assign cnt.stride_value = job.stride;

    // Status levels, done stays high through DONE and IDLE
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            ready <= 1'b0;
            done  <= 1'b0;
        end
        else begin
            ready <= (state == IDLE);
            done  <= (state == IDLE) | (state == DONE);
        end
    end

endmodule

`default_nettype wire

// ==== source/request_formatter.sv ====
/*
 * Request packet formatter
 * Turns the current vertex index into a memory request and registers
 * it onto the queue write port
 */
`timescale 1ns/1ps
`default_nettype none

`include "stride_defs.svh"

module request_formatter import memory_packet_pkg::*, stride_config_pkg::*; (
    input  logic                       ap_clk,
    input  logic                       areset_engine,
    input  logic                       emit,
    input  stride_job_t                job,
    input  logic [`STRIDE_INDEX_W-1:0] index,
    request_fifo_if.writer             fifo_wr
);

    request_payload_t packet;

    always_comb begin
        packet.route = job.route;
        packet.base  = job.index_start;
        packet.shift = job.shift;
        packet.index = index;
        // Left when direction is set
        if (job.shift.direction) begin
            packet.offset = index << job.shift.amount;
        end
        else begin
            packet.offset = index >> job.shift.amount;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            fifo_wr.wr_en <= 1'b0;
        end
        else begin
            fifo_wr.wr_en <= emit;
        end
    end

    always_ff @(posedge ap_clk) begin
        fifo_wr.din <= packet;
    end

endmodule

`default_nettype wire

// ==== source/request_fifo.sv ====
/*
 * Request queue
 * Synchronous circular buffer with an almost-full flag and
 * registered read data qualified by valid
 */
`timescale 1ns/1ps
`default_nettype none

`include "stride_defs.svh"

module request_fifo import memory_packet_pkg::*; (
    input  logic            ap_clk,
    input  logic            areset_engine,
    request_fifo_if.storage fifo
);

    localparam int unsigned DEPTH = `STRIDE_FIFO_DEPTH;
    localparam int unsigned PTR_W = `STRIDE_FIFO_PTR_W;
    localparam logic [PTR_W:0] FULL_LEVEL = (PTR_W+1)'(DEPTH);
    localparam logic [PTR_W:0] PROG_LEVEL = (PTR_W+1)'(`STRIDE_PROG_FULL);

    request_payload_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   occupancy;
    logic             wr_accept;
    logic             rd_accept;

    assign fifo.full      = (occupancy == FULL_LEVEL);
    assign fifo.empty     = (occupancy == '0);
    assign fifo.prog_full = (occupancy >= PROG_LEVEL);

    // Writes into a full queue are dropped
    assign wr_accept = fifo.wr_en & ~fifo.full;
    assign rd_accept = fifo.rd_en & ~fifo.empty;

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end
        else begin
            if (wr_accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_accept) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_accept, rd_accept})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Storage and read data
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (wr_accept) begin
            mem[wr_ptr] <= fifo.din;
        end
        if (rd_accept) begin
            fifo.dout <= mem[rd_ptr];
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            fifo.valid <= 1'b0;
        end
        else begin
            fifo.valid <= rd_accept;
        end
    end

endmodule

`default_nettype wire

// ==== source/stride_index_generator.sv ====
/*
 * Vertex-ID stride index generator
 * Emits one memory request per index of a strided job into a request
 * queue that the consumer drains with a read strobe
 */
`timescale 1ns/1ps
`default_nettype none

`include "stride_defs.svh"

module stride_index_generator import stride_config_pkg::*, memory_packet_pkg::*; (
    input  logic                       ap_clk,
    input  logic                       areset_engine,
    // Job configuration
    input  logic                       cfg_valid,
    input  logic [`STRIDE_INDEX_W-1:0] cfg_index_start,
    input  logic [`STRIDE_INDEX_W-1:0] cfg_index_end,
    input  logic [`STRIDE_INDEX_W-1:0] cfg_stride,
    input  logic [`STRIDE_ROUTE_W-1:0] cfg_route,
    input  logic                       cfg_shift_left,
    input  logic [`STRIDE_SHIFT_W-1:0] cfg_shift_amount,
    input  logic                       pause,
    // Request queue read side
    input  logic                       request_rd_en,
    output logic                       request_valid,
    output logic [`STRIDE_INDEX_W-1:0] request_index,
    output logic [`STRIDE_INDEX_W-1:0] request_base,
    output logic [`STRIDE_INDEX_W-1:0] request_offset,
    output logic [`STRIDE_ROUTE_W-1:0] request_route,
    output logic                       request_shift_left,
    output logic [`STRIDE_SHIFT_W-1:0] request_shift_amount,
    output logic                       ready,
    output logic                       done
);

    stride_job_t cfg_job;
    stride_job_t job;
    logic        emit;

    index_counter_if counter_bus ();
    request_fifo_if  fifo_bus ();

    assign cfg_job.index_start     = cfg_index_start;
    assign cfg_job.index_end       = cfg_index_end;
    assign cfg_job.stride          = cfg_stride;
    assign cfg_job.route           = cfg_route;
    assign cfg_job.shift.direction = cfg_shift_left;
    assign cfg_job.shift.amount    = cfg_shift_amount;

    stride_sequencer u_sequencer (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .cfg_valid     (cfg_valid),
        .pause         (pause),
        .cfg_in        (cfg_job),
        .job           (job),
        .cnt           (counter_bus.initiator),
        .fifo_mon      (fifo_bus.monitor),
        .emit          (emit),
        .ready         (ready),
        .done          (done)
    );

    index_counter u_counter (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .cnt           (counter_bus.target)
    );

    request_formatter u_formatter (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .emit          (emit),
        .job           (job),
        .index         (counter_bus.count),
        .fifo_wr       (fifo_bus.writer)
    );

    request_fifo u_fifo (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .fifo          (fifo_bus.storage)
    );

    // Consumer side of the queue
    assign fifo_bus.rd_en       = request_rd_en;
    assign request_valid        = fifo_bus.valid;
    assign request_index        = fifo_bus.dout.index;
    assign request_base         = fifo_bus.dout.base;
    assign request_offset       = fifo_bus.dout.offset;
    assign request_route        = fifo_bus.dout.route;
    assign request_shift_left   = fifo_bus.dout.shift.direction;
    assign request_shift_amount = fifo_bus.dout.shift.amount;

endmodule

`default_nettype wire

// ==== bench/stride_index_generator_sva.sv ====
/*
 * Stride index generator port assertions
 * Read data qualification and status level relations
 */
`timescale 1ns/1ps
`default_nettype none

module stride_index_generator_sva (
    input logic ap_clk,
    input logic areset_engine,
    input logic request_rd_en,
    input logic request_valid,
    input logic ready,
    input logic done
);

    // Valid only ever answers a strobe from the cycle before
    valid_needs_read: assert property (@(posedge ap_clk) disable iff (areset_engine)
        !$past(request_rd_en) |-> !request_valid)
        else $error("request_valid high without a read strobe in the previous cycle");

    ready_implies_done: assert property (@(posedge ap_clk) disable iff (areset_engine)
        ready |-> done)
        else $error("ready high while done is low");

    valid_low_in_reset: assert property (@(posedge ap_clk)
        areset_engine && $past(areset_engine) |-> !request_valid)
        else $error("request_valid high during reset");

endmodule

bind stride_index_generator stride_index_generator_sva u_sva (
    .ap_clk        (ap_clk),
    .areset_engine (areset_engine),
    .request_rd_en (request_rd_en),
    .request_valid (request_valid),
    .ready         (ready),
    .done          (done)
);

`default_nettype wire

// ==== bench/stride_index_generator_tb.sv ====
/*
 * Stride index generator testbench
 * Directed jobs checked against a model built from the index sequence
 * and offset rules, with random strides, reader gaps and pause pulses
 */
`timescale 1ns/1ps
`default_nettype none

`include "stride_defs.svh"

module stride_index_generator_tb;

    localparam int JOB_INDEX_BUDGET = 150;
    localparam int WATCHDOG_CYCLES  = JOB_INDEX_BUDGET * 20 + 600;
    // Hold mode keeps the reader off well past the almost-full stall
    localparam int HOLD_CYCLES      = 60;

    logic                       ap_clk = 1'b0;
    logic                       areset_engine;
    logic                       cfg_valid;
    logic [`STRIDE_INDEX_W-1:0] cfg_index_start;
    logic [`STRIDE_INDEX_W-1:0] cfg_index_end;
    logic [`STRIDE_INDEX_W-1:0] cfg_stride;
    logic [`STRIDE_ROUTE_W-1:0] cfg_route;
    logic                       cfg_shift_left;
    logic [`STRIDE_SHIFT_W-1:0] cfg_shift_amount;
    logic                       pause;
    logic                       request_rd_en;
    logic                       request_valid;
    logic [`STRIDE_INDEX_W-1:0] request_index;
    logic [`STRIDE_INDEX_W-1:0] request_base;
    logic [`STRIDE_INDEX_W-1:0] request_offset;
    logic [`STRIDE_ROUTE_W-1:0] request_route;
    logic                       request_shift_left;
    logic [`STRIDE_SHIFT_W-1:0] request_shift_amount;
    logic                       ready;
    logic                       done;

    integer seed   = 32'h88e2;
    int     errors = 0;
    int     checks = 0;

    stride_index_generator dut (.*);

    always #2 ap_clk = ~ap_clk;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // Offset rule, direction 1 shifts left
    function automatic logic [31:0] shifted_offset(input logic [31:0] idx,
                                                   input logic left, input logic [4:0] amt);
        logic [31:0] result;
        result = idx;
        // One bit position per unit of the shift amount
        for (int i = 0; i < amt; i++) begin
            if (left) begin
                result = {result[30:0], 1'b0};
            end
            else begin
                result = {1'b0, result[31:1]};
            end
        end
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("[FAIL] %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic check_true(input string what, input bit cond);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Error at %0t ns: %s", $time, what);
        end
    endtask

    task automatic wait_idle();
        while (!(ready && done)) begin
            @(posedge ap_clk);
            #1;
        end
    endtask

    // ------------------------------------------------------------------------
    // One job: load, drain with the chosen reader, compare with the model
    // Read modes are 0 eager, 1 random gaps, 2 hold until done
    // ------------------------------------------------------------------------
    task automatic run_job(input logic [31:0] start, input logic [31:0] stop,
                           input logic [31:0] step, input logic [7:0] route,
                           input logic left, input logic [4:0] amt,
                           input int read_mode, input bit with_pause);
        logic [31:0] exp_q[$];
        logic [31:0] v;
        logic [31:0] exp_idx;
        logic [31:0] rnd;
        int          expected_count;
        int          received = 0;
        int          cycles = 0;
        bit          fell = 1'b0;
        bit          finished = 1'b0;
        bit          last_rd = 1'b0;
        bit          drained = 1'b0;
        for (v = start; v < stop; v = v + step) begin
            exp_q.push_back(v);
        end
        expected_count = (start < stop) ? int'((stop - start + step - 1) / step) : 0;
        wait_idle();
        cfg_index_start  = start;
        cfg_index_end    = stop;
        cfg_stride       = step;
        cfg_route        = route;
        cfg_shift_left   = left;
        cfg_shift_amount = amt;
        cfg_valid        = 1'b1;
        @(posedge ap_clk);
        #1;
        cfg_valid = 1'b0;
        while (!drained) begin
            if (request_valid) begin
                received++;
                if (exp_q.size() == 0) begin
                    check_true("packet received beyond the end of the job", 1'b0);
                end
                else begin
                    exp_idx = exp_q.pop_front();
                    check_value("request_index", exp_idx, request_index);
                    check_value("request_base", start, request_base);
                    check_value("request_offset", shifted_offset(exp_idx, left, amt),
                                request_offset);
                    check_value("request_route", {24'd0, route}, {24'd0, request_route});
                    check_value("request_shift", {26'd0, left, amt},
                                {26'd0, request_shift_left, request_shift_amount});
                end
            end
            // Strobe into an empty queue leaves valid low
            drained = finished && last_rd && !request_valid;
            fell    = fell || !done;
            if (cycles == 3) begin
                check_true("done did not fall within 3 cycles of job acceptance", fell);
            end
            finished = fell && done;
            rnd      = next_random();
            case (read_mode)
                0:       request_rd_en = 1'b1;
                1:       request_rd_en = finished | rnd[0];
                default: request_rd_en = finished | (cycles >= HOLD_CYCLES);
            endcase
            pause   = with_pause && !finished && (rnd[2:1] == 2'b00);
            last_rd = request_rd_en;
            if (!drained) begin
                @(posedge ap_clk);
                #1;
                cycles++;
            end
        end
        request_rd_en = 1'b0;
        pause         = 1'b0;
        check_value("packet count", expected_count, received);
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic test_reset_levels();
        int n = 0;
        check_value("ready", 32'd0, {31'd0, ready});
        check_value("done", 32'd0, {31'd0, done});
        check_value("request_valid", 32'd0, {31'd0, request_valid});
        areset_engine = 1'b0;
        while (!(ready && done)) begin
            @(posedge ap_clk);
            #1;
            n++;
        end
        check_true("ready and done took more than 3 cycles to rise after reset", n <= 3);
        // No job loaded, so strobes find nothing
        request_rd_en = 1'b1;
        repeat (6) begin
            @(posedge ap_clk);
            #1;
            check_value("request_valid", 32'd0, {31'd0, request_valid});
        end
        request_rd_en = 1'b0;
    endtask

    task automatic test_random_strides();
        logic [31:0] rnd;
        logic [31:0] rnd2;
        logic [31:0] step;
        logic [31:0] start;
        logic [31:0] span;
        for (int k = 0; k < 4; k++) begin
            rnd   = next_random();
            rnd2  = next_random();
            step  = 32'd2 + (rnd % 32'd7);
            start = {26'd0, rnd[13:8]};
            // Remainder keeps the end off the stride grid
            span  = step * 32'd10 + 32'd1 + ({24'd0, rnd[23:16]} % (step - 32'd1));
            run_job(start, start + span, step, rnd2[15:8], k[0], rnd2[4:0], 1, 1'b0);
        end
    endtask

    task automatic test_empty_job();
        run_job(32'd500, 32'd500, 32'd4, 8'h11, 1'b1, 5'd2, 0, 1'b0);
        run_job(32'd600, 32'd200, 32'd4, 8'h22, 1'b0, 5'd2, 0, 1'b0);
        run_job(32'd10, 32'd46, 32'd3, 8'h77, 1'b0, 5'd1, 1, 1'b0);
    endtask

    initial begin
        areset_engine    = 1'b1;
        cfg_valid        = 1'b0;
        cfg_index_start  = '0;
        cfg_index_end    = '0;
        cfg_stride       = '0;
        cfg_route        = '0;
        cfg_shift_left   = 1'b0;
        cfg_shift_amount = '0;
        pause            = 1'b0;
        request_rd_en    = 1'b0;
        repeat (3) @(posedge ap_clk);
        #1;
        test_reset_levels();
        run_job(32'd100, 32'd120, 32'd1, 8'h5a, 1'b1, 5'd3, 0, 1'b0);
        test_random_strides();
        // 40 indices against an idle reader forces the almost-full stall
        run_job(32'd7, 32'd207, 32'd5, 8'hc3, 1'b0, 5'd2, 2, 1'b0);
        run_job(32'd1000, 32'd1090, 32'd3, 8'h3c, 1'b1, 5'd4, 0, 1'b1);
        test_empty_job();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        $display("Watchdog expired before the tests completed, %0d errors so far", errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+source
source/stride_config_pkg.sv
source/memory_packet_pkg.sv
source/stride_ifs.sv
source/index_counter.sv
source/stride_sequencer.sv
source/request_formatter.sv
source/request_fifo.sv
source/stride_index_generator.sv
bench/stride_index_generator_sva.sv
bench/stride_index_generator_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the stride index generator testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f \
    --top-module stride_index_generator_tb -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
